//--- bench/n64vidTb.sv
//////////////////////////////////////////////////
// Table-driven testbench for n64vidTop
// Vsync-low rows sit at least CFG_SETTLE + 8 cycles
// after a real mode change, so adoption is unambiguous
//////////////////////////////////////////////////

`default_nettype none

`include "n64vid_params.svh"

module n64vidTb;
  timeunit 1ns;
  timeprecision 100ps;

  // Mode codes of the reference model
  localparam int M_RGB   = 0;
  localparam int M_RGSB  = 1;
  localparam int M_YPBPR = 2;
  // Sync words {spare, vsyncN, clampN, hsyncN, csyncN}
  localparam logic [6:0] F_LINE = 7'h0F;
  localparam logic [6:0] F_HS   = 7'h0C;
  localparam logic [6:0] F_VS   = 7'h06;
  localparam logic [6:0] F_VSN  = 7'h07;
  // Jumpers as {nEnYPbPr, nEnRGsB}
  localparam logic [1:0] J_RGB   = 2'b11;
  localparam logic [1:0] J_RGSB  = 2'b10;
  localparam logic [1:0] J_YPBPR = 2'b01;
  localparam logic [1:0] J_BOTH  = 2'b00;

  typedef struct packed {
    logic [6:0] flags;
    logic [1:0] jmp;
    logic       abort;
    logic [6:0] r;
    logic [6:0] g;
    logic [6:0] b;
  } stimRow_t;

  typedef struct packed {
    logic [6:0] r;
    logic [6:0] g;
    logic [6:0] b;
    logic       cs;
    logic       hs;
    logic       vs;
  } expPix_t;

  logic VCLK = 1'b0;
  logic rst_i;
  logic nVDSYNC_i;
  logic [`COLOR_W-1:0] vd_i;
  logic nEnRGsB_i;
  logic nEnYPbPr_i;
  logic [`COLOR_W-1:0] vdR_o;
  logic [`COLOR_W-1:0] vdG_o;
  logic [`COLOR_W-1:0] vdB_o;
  logic pixValid_o;
  logic nCSYNC_o;
  logic nHSYNC_o;
  logic nVSYNC_o;

  stimRow_t stim[$];
  expPix_t  expQ[$];
  expPix_t  expd;
  int seed = 15314;
  int errors = 0;
  int pushed = 0;
  int seen = 0;
  int cycles = 0;
  int cycLimit = 200;
  int drainWords = 0;
  // Reference model state
  int refMode = M_RGB;
  int heldMode = M_RGB;
  int chgCyc = 0;
  int wordCyc = 0;

  n64vidTop uut (
    .VCLK       (VCLK),
    .rst_i      (rst_i),
    .nVDSYNC_i  (nVDSYNC_i),
    .vd_i       (vd_i),
    .nEnRGsB_i  (nEnRGsB_i),
    .nEnYPbPr_i (nEnYPbPr_i),
    .vdR_o      (vdR_o),
    .vdG_o      (vdG_o),
    .vdB_o      (vdB_o),
    .pixValid_o (pixValid_o),
    .nCSYNC_o   (nCSYNC_o),
    .nHSYNC_o   (nHSYNC_o),
    .nVSYNC_o   (nVSYNC_o)
  );

  // 4 ns VCLK
  always #2 VCLK = ~VCLK;

  // Append n bus cycles with fresh random colours
  task automatic addRows(input int n, input logic [6:0] flags, input logic [1:0] jmp,
                         input logic abort);
    stimRow_t row;
    repeat (n) begin
      row.flags = flags;
      row.jmp   = jmp;
      row.abort = abort;
      row.r     = 7'($random(seed));
      row.g     = 7'($random(seed));
      row.b     = 7'($random(seed));
      stim.push_back(row);
    end
  endtask

  // One bus word, just after the rising edge
  task automatic driveWord(input logic nsync, input logic [6:0] w);
    @(posedge VCLK);
    #0.5;
    nVDSYNC_i = nsync;
    vd_i      = w;
  endtask

  // Jumper priority, YPbPr first
  function automatic int decodeJumpers(input logic [1:0] jmp);
    if (!jmp[1]) begin
      return M_YPBPR;
    end else if (!jmp[0]) begin
      return M_RGSB;
    end
    return M_RGB;
  endfunction

  // Expected DAC word for one pixel
  function automatic expPix_t formatPixel(input int mode, input logic [6:0] flags,
                                          input logic [6:0] r, input logic [6:0] g,
                                          input logic [6:0] b);
    int y;
    int pb;
    int pr;
    expPix_t e;
    y    = (2 * int'(r) + 5 * int'(g) + int'(b)) / 8;
    // Arithmetic shift floors the halved difference
    pb   = 64 + ((int'(b) - y) >>> 1);
    pr   = 64 + ((int'(r) - y) >>> 1);
    e.cs = flags[0];
    e.hs = flags[1];
    e.vs = flags[3];
    e.r  = r;
    e.g  = g;
    e.b  = b;
    if (mode == M_RGSB && !flags[0]) begin
      e.g = '0;
    end else if (mode == M_YPBPR) begin
      e.r = pr[6:0];
      e.g = flags[0] ? y[6:0] : 7'd0;
      e.b = pb[6:0];
    end
    return e;
  endfunction

  task automatic reportCounts();
    $display("Pixels expected %0d, seen %0d, errors %0d", pushed, seen, errors);
  endtask

  //////////////////////////////////////////////////
  // Output monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge VCLK) begin
    if (!rst_i && pixValid_o) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("ERROR at %0t ns: pixValid_o pulse with no pixel expected", $time);
      end else begin
        expd = expQ.pop_front();
        seen++;
        if ({vdR_o, vdG_o, vdB_o} !== {expd.r, expd.g, expd.b}) begin
          errors++;
          $display("ERROR at %0t ns: pixel %0d got R%0d G%0d B%0d, expected R%0d G%0d B%0d",
                   $time, seen, vdR_o, vdG_o, vdB_o, expd.r, expd.g, expd.b);
        end
        if ({nCSYNC_o, nHSYNC_o, nVSYNC_o} !== {expd.cs, expd.hs, expd.vs}) begin
          errors++;
          $display("ERROR at %0t ns: pixel %0d sync c/h/v %b%b%b, expected %b%b%b",
                   $time, seen, nCSYNC_o, nHSYNC_o, nVSYNC_o, expd.cs, expd.hs, expd.vs);
        end
      end
    end
  end

  // Hang guard
  always @(posedge VCLK) begin
    cycles++;
    if (cycles > cycLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycLimit);
      reportCounts();
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  initial begin
    int i;
    int jm;
    stimRow_t row;
    rst_i      = 1'b1;
    nVDSYNC_i  = 1'b1;
    vd_i       = '0;
    nEnRGsB_i  = 1'b1;
    nEnYPbPr_i = 1'b1;
    // RGB after reset, then blanking and a vsync without change
    addRows(3, F_LINE, J_RGB, 1'b0);
    addRows(1, F_HS, J_RGB, 1'b0);
    addRows(1, F_VS, J_RGB, 1'b0);
    addRows(2, F_LINE, J_RGB, 1'b0);
    // YPbPr held, adopted at the vsync row
    addRows(6, F_LINE, J_YPBPR, 1'b0);
    addRows(1, F_VS, J_YPBPR, 1'b0);
    addRows(4, F_LINE, J_YPBPR, 1'b0);
    addRows(2, F_HS, J_YPBPR, 1'b0);
    addRows(1, F_VSN, J_YPBPR, 1'b0);
    // Short RGB glitch from settled jumpers, with a vsync inside it
    addRows(1, F_LINE, J_YPBPR, 1'b0);
    addRows(1, F_VS, J_RGB, 1'b0);
    // Both jumpers set still decode as YPbPr
    addRows(5, F_LINE, J_BOTH, 1'b0);
    addRows(1, F_VS, J_YPBPR, 1'b0);
    // RGsB with green cut during csync
    addRows(6, F_LINE, J_RGSB, 1'b0);
    addRows(1, F_VS, J_RGSB, 1'b0);
    addRows(3, F_HS, J_RGSB, 1'b0);
    addRows(3, F_LINE, J_RGSB, 1'b0);
    // Aborted pixels
    addRows(1, F_LINE, J_RGSB, 1'b1);
    addRows(2, F_LINE, J_RGSB, 1'b0);
    addRows(1, F_HS, J_RGSB, 1'b1);
    addRows(1, F_HS, J_RGSB, 1'b0);
    // Back to RGB
    addRows(6, F_LINE, J_RGB, 1'b0);
    addRows(1, F_VS, J_RGB, 1'b0);
    addRows(3, F_LINE, J_RGB, 1'b0);
    cycLimit = stim.size() * 4 + 200;

    repeat (2) @(posedge VCLK);
    #0.5;
    rst_i = 1'b0;
    @(negedge VCLK);
    if (pixValid_o !== 1'b0 || {nCSYNC_o, nHSYNC_o, nVSYNC_o} !== 3'b111) begin
      errors++;
      $display("ERROR at %0t ns: reset state pixValid_o %b sync %b%b%b", $time,
               pixValid_o, nCSYNC_o, nHSYNC_o, nVSYNC_o);
    end

    for (i = 0; i < stim.size(); i++) begin
      row = stim[i];
      jm  = decodeJumpers(row.jmp);
      // Hold time restarts on a change of decoded mode
      if (jm != heldMode) begin
        heldMode = jm;
        chgCyc   = wordCyc;
      end
      if (!row.flags[3] && jm != refMode && (wordCyc - chgCyc) >= `CFG_SETTLE + 8) begin
        refMode = jm;
      end
      driveWord(1'b0, row.flags);
      {nEnYPbPr_i, nEnRGsB_i} = row.jmp;
      driveWord(1'b1, row.r);
      driveWord(1'b1, row.g);
      wordCyc += 3;
      // Aborted rows end before blue
      if (!row.abort) begin
        driveWord(1'b1, row.b);
        wordCyc++;
        expQ.push_back(formatPixel(refMode, row.flags, row.r, row.g, row.b));
        pushed++;
      end
    end

    // Drain within a few words of the output latency, then idle words for stray pulses
    while (expQ.size() != 0 && drainWords < 8) begin
      driveWord(1'b1, '0);
      drainWords++;
    end
    repeat (4) driveWord(1'b1, '0);
    if (seen != pushed) begin
      errors++;
      $display("ERROR at %0t ns: %0d pixels expected, %0d seen", $time, pushed, seen);
    end
    reportCounts();
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- common/cfgLink_if.sv
//////////////////////////////////////////////////
// Four-phase req/ack link for the output mode
// mode must stay constant while req is high
//////////////////////////////////////////////////

`default_nettype none

interface cfgLink_if
  import n64vid_pkg::*;
();

  // Request from the sequencer
  logic     req;
  // Acknowledge from the formatter
  logic     ack;
  // Requested output mode
  outMode_e mode;

  // Jumper side, sets mode then raises req
  modport sequencer (output req, output mode, input ack);

  // Video side, adopts mode at vsync then raises ack
  modport formatter (input req, input mode, output ack);

endinterface

`default_nettype wire

//--- common/n64vid_params.svh
//////////////////////////////////////////////////
// Build constants for the N64 video input path
// COLOR_W is fixed by the console bus at 7 bits
// CFG_SETTLE counts VCLK cycles, about 0.33 us at 16 cycles
//////////////////////////////////////////////////

`ifndef N64VID_PARAMS_SVH
`define N64VID_PARAMS_SVH

// Width of one bus word and of each output channel
`define COLOR_W 7

// Stable cycles the jumpers need before a change is taken
`define CFG_SETTLE 16

`endif

//--- common/n64vid_pkg.sv
//////////////////////////////////////////////////
// Shared types for the video input path
// Sync bit order follows the console bus, csync in bit 0
//////////////////////////////////////////////////

`default_nettype none

`include "n64vid_params.svh"

package n64vid_pkg;

  // Output format chosen by the jumpers
  typedef enum logic [1:0] {
    MODE_RGB   = 2'd0,
    MODE_RGSB  = 2'd1,
    MODE_YPBPR = 2'd2
  } outMode_e;

  // Sync word as sent while nVDSYNC is low, all flags active low
  typedef struct packed {
    logic [2:0] spare;
    logic       vsyncN;
    logic       clampN;
    logic       hsyncN;
    logic       csyncN;
  } syncFlags_s;

  // One bus word, read as flags or as a colour sample
  typedef union packed {
    syncFlags_s          flags;
    logic [`COLOR_W-1:0] color;
  } vdWord_u;

  // Assembled pixel
  typedef struct packed {
    logic [`COLOR_W-1:0] r;
    logic [`COLOR_W-1:0] g;
    logic [`COLOR_W-1:0] b;
  } rgbPix_s;

endpackage

`default_nettype wire

//--- config/cfgSequencer.sv
//////////////////////////////////////////////////
// Jumper debounce and mode request FSM
// nEnYPbPr_i wins over nEnRGsB_i when both are set
// Only a mode different from the last sent one is requested
//////////////////////////////////////////////////

`default_nettype none

module cfgSequencer
  import n64vid_pkg::*;
(
  input  wire logic   VCLK,
  input  wire logic   rst_i,
  input  wire logic   nEnRGsB_i,
  input  wire logic   nEnYPbPr_i,
  input  wire logic   settled_i,
  output logic        restart_o,
  cfgLink_if.sequencer cfg
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAITACKLOW
  } seqState_e;

  seqState_e  state;
  // Jumpers as {nEnYPbPr, nEnRGsB}
  logic [1:0] jmpQ;
  logic [1:0] jmpPrev;
  logic       reqQ;
  outMode_e   decMode;
  outMode_e   lastMode;

  // Priority decode of the held jumper value
  always_comb begin
    if (!jmpPrev[1]) begin
      decMode = MODE_YPBPR;
    end else if (!jmpPrev[0]) begin
      decMode = MODE_RGSB;
    end else begin
      decMode = MODE_RGB;
    end
  end

  //////////////////////////////////////////////////
  // Sampling and handshake
  //////////////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      jmpQ      <= 2'b11;
      jmpPrev   <= 2'b11;
      restart_o <= 1'b0;
      state     <= IDLE;
      reqQ      <= 1'b0;
      lastMode  <= MODE_RGB;
    end else begin
      jmpQ      <= {nEnYPbPr_i, nEnRGsB_i};
      jmpPrev   <= jmpQ;
      // Any change restarts the settle count
      restart_o <= (jmpQ != jmpPrev);
      case (state)
        IDLE: begin
          // Settled is stale while a restart is still on its way to the timer
          if (settled_i && !restart_o && (decMode != lastMode) && !cfg.ack) begin
            // Mode is loaded with req and held until the next IDLE
            lastMode <= decMode;
            reqQ     <= 1'b1;
            state    <= REQ;
          end
        end
        REQ: begin
          if (cfg.ack) begin
            reqQ  <= 1'b0;
            state <= WAITACKLOW;
          end
        end
        WAITACKLOW: begin
          // Formatter drops ack after it sees req low
          if (!cfg.ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign cfg.req  = reqQ;
  assign cfg.mode = lastMode;

endmodule

`default_nettype wire

//--- config/settleTimer.sv
//////////////////////////////////////////////////
// Stability counter for the jumper inputs
// Saturates at CFG_SETTLE until the next restart
//////////////////////////////////////////////////

`default_nettype none

`include "n64vid_params.svh"

module settleTimer (
  input  wire logic VCLK,
  input  wire logic rst_i,
  input  wire logic restart_i,
  output logic      settled_o
);

  localparam int CNT_W = $clog2(`CFG_SETTLE + 1);

  logic [CNT_W-1:0] count;

  // Count stable cycles, hold at the limit
  always_ff @(posedge VCLK) begin
    if (rst_i || restart_i) begin
      count <= '0;
    end else if (count != CNT_W'(`CFG_SETTLE)) begin
      count <= count + 1'b1;
    end
  end

  // High while the limit is held
  assign settled_o = (count == CNT_W'(`CFG_SETTLE));

endmodule

`default_nettype wire

//--- convert/colorFormatter.sv
//////////////////////////////////////////////////
// RGB / RGsB / YPbPr output stage, two pipeline steps
// New modes take effect at the next vsync-low sync word
// YPbPr puts Y on G, Pb on B and Pr on R
//////////////////////////////////////////////////

`default_nettype none

`include "n64vid_params.svh"

module colorFormatter
  import n64vid_pkg::*;
(
  input  wire logic         VCLK,
  input  wire logic         rst_i,
  input  wire rgbPix_s      pix_i,
  input  wire logic         pixValid_i,
  input  wire syncFlags_s   sync_i,
  input  wire logic         syncStrobe_i,
  cfgLink_if.formatter      cfg,
  output logic [`COLOR_W-1:0] vdR_o,
  output logic [`COLOR_W-1:0] vdG_o,
  output logic [`COLOR_W-1:0] vdB_o,
  output logic              pixValid_o,
  output logic              nCSYNC_o,
  output logic              nHSYNC_o,
  output logic              nVSYNC_o
);

  outMode_e            activeMode;
  logic                ackQ;
  // Stage 1 registers
  rgbPix_s             pixQ;
  logic [`COLOR_W-1:0] yQ;
  outMode_e            modeQ;
  logic                csyncQ;
  logic                validQ;
  syncFlags_s          syncQ;
  // Luma sum and the offset chroma sums
  logic [9:0]          ySum;
  logic [7:0]          pbSum;
  logic [7:0]          prSum;

  //////////////////////////////////////////////////
  // Mode adoption
  //////////////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      activeMode <= MODE_RGB;
      ackQ       <= 1'b0;
    end else if (ackQ) begin
      if (!cfg.req) begin
        ackQ <= 1'b0;
      end
    end else if (cfg.req && syncStrobe_i && !sync_i.vsyncN) begin
      // Frame boundary
      activeMode <= cfg.mode;
      ackQ       <= 1'b1;
    end
  end

  assign cfg.ack = ackQ;

  //////////////////////////////////////////////////
  // Stage 1 computes luma
  //////////////////////////////////////////////////

  // 2R + 5G + B, at most 1016
  assign ySum = {2'b00, pix_i.r, 1'b0} + ({3'b000, pix_i.g} * 10'd5) + {3'b000, pix_i.b};

  always_ff @(posedge VCLK) begin
    if (pixValid_i) begin
      pixQ   <= pix_i;
      yQ     <= ySum[9:3];
      // Mode is fixed per pixel
      modeQ  <= activeMode;
      csyncQ <= sync_i.csyncN;
    end
  end

  //////////////////////////////////////////////////
  // Stage 2 selects the output format
  //////////////////////////////////////////////////

  // 64 + floor(d/2) equals (128 + d) >> 1, never negative
  assign pbSum = 8'd128 + {1'b0, pixQ.b} - {1'b0, yQ};
  assign prSum = 8'd128 + {1'b0, pixQ.r} - {1'b0, yQ};

  always_ff @(posedge VCLK) begin
    if (validQ) begin
      case (modeQ)
        MODE_RGSB: begin
          vdR_o <= pixQ.r;
          vdG_o <= csyncQ ? pixQ.g : '0;
          vdB_o <= pixQ.b;
        end
        MODE_YPBPR: begin
          vdR_o <= prSum[7:1];
          vdG_o <= csyncQ ? yQ : '0;
          vdB_o <= pbSum[7:1];
        end
        default: begin
          vdR_o <= pixQ.r;
          vdG_o <= pixQ.g;
          vdB_o <= pixQ.b;
        end
      endcase
    end
  end

  // Valid and sync share the two-step delay of the pixel
  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      validQ     <= 1'b0;
      pixValid_o <= 1'b0;
      syncQ      <= '1;
      nCSYNC_o   <= 1'b1;
      nHSYNC_o   <= 1'b1;
      nVSYNC_o   <= 1'b1;
    end else begin
      validQ     <= pixValid_i;
      pixValid_o <= validQ;
      syncQ      <= sync_i;
      nCSYNC_o   <= syncQ.csyncN;
      nHSYNC_o   <= syncQ.hsyncN;
      nVSYNC_o   <= syncQ.vsyncN;
    end
  end

endmodule

`default_nettype wire

//--- demux/vidDemux.sv
//////////////////////////////////////////////////
// Splits the 4-word bus cycle into sync and RGB
// Colour words before the first sync are ignored
//////////////////////////////////////////////////

`default_nettype none

`include "n64vid_params.svh"

module vidDemux
  import n64vid_pkg::*;
(
  input  wire logic                VCLK,
  input  wire logic                rst_i,
  input  wire logic                nVDSYNC_i,
  input  wire logic [`COLOR_W-1:0] vd_i,
  output rgbPix_s                  pix_o,
  output logic                     pixValid_o,
  output syncFlags_s               sync_o,
  output logic                     syncStrobe_o
);

  // Phase of the next colour word
  localparam logic [1:0] PH_R    = 2'd0;
  localparam logic [1:0] PH_G    = 2'd1;
  localparam logic [1:0] PH_B    = 2'd2;
  // Pixel done or aborted, wait for a sync word
  localparam logic [1:0] PH_WAIT = 2'd3;

  vdWord_u             word;
  logic [1:0]          phase;
  logic [`COLOR_W-1:0] rQ;
  logic [`COLOR_W-1:0] gQ;

  // Same bus word, decoded by nVDSYNC
  assign word = vdWord_u'(vd_i);

  //////////////////////////////////////////////////
  // Phase tracking and strobes
  //////////////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      phase        <= PH_WAIT;
      pixValid_o   <= 1'b0;
      syncStrobe_o <= 1'b0;
      sync_o       <= '1;
    end else begin
      pixValid_o   <= 1'b0;
      syncStrobe_o <= 1'b0;
      if (!nVDSYNC_i) begin
        // Sync word restarts the cycle, a partial pixel is dropped
        sync_o       <= word.flags;
        syncStrobe_o <= 1'b1;
        phase        <= PH_R;
      end else begin
        case (phase)
          PH_R: phase <= PH_G;
          PH_G: phase <= PH_B;
          PH_B: begin
            // Blue lands, pixel is complete
            pixValid_o <= 1'b1;
            phase      <= PH_WAIT;
          end
          default: phase <= PH_WAIT;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Colour capture
  //////////////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (nVDSYNC_i) begin
      case (phase)
        PH_R: rQ <= word.color;
        PH_G: gQ <= word.color;
        // Blue goes straight into the output word
        PH_B: pix_o <= '{r: rQ, g: gQ, b: word.color};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/n64vidTop.sv
//////////////////////////////////////////////////
// Video input path, all logic on VCLK
// rst_i must already be synchronous to VCLK
// Pixels leave two cycles after their blue word
//////////////////////////////////////////////////

`default_nettype none

`include "n64vid_params.svh"

module n64vidTop
  import n64vid_pkg::*;
(
  input  wire logic                VCLK,
  input  wire logic                rst_i,
  // Console video bus
  input  wire logic                nVDSYNC_i,
  input  wire logic [`COLOR_W-1:0] vd_i,
  // Format jumpers, active low
  input  wire logic                nEnRGsB_i,
  input  wire logic                nEnYPbPr_i,
  // Video out to the DAC
  output logic [`COLOR_W-1:0]      vdR_o,
  output logic [`COLOR_W-1:0]      vdG_o,
  output logic [`COLOR_W-1:0]      vdB_o,
  output logic                     pixValid_o,
  output logic                     nCSYNC_o,
  output logic                     nHSYNC_o,
  output logic                     nVSYNC_o
);

  //////////////////////////////////////////////////
  // Configuration path
  //////////////////////////////////////////////////

  logic restart;
  logic settled;

  cfgLink_if cfg ();

  settleTimer uSettleTimer (
    .VCLK      (VCLK),
    .rst_i     (rst_i),
    .restart_i (restart),
    .settled_o (settled)
  );

  cfgSequencer uCfgSequencer (
    .VCLK       (VCLK),
    .rst_i      (rst_i),
    .nEnRGsB_i  (nEnRGsB_i),
    .nEnYPbPr_i (nEnYPbPr_i),
    .settled_i  (settled),
    .restart_o  (restart),
    .cfg        (cfg.sequencer)
  );

  //////////////////////////////////////////////////
  // Pixel path
  //////////////////////////////////////////////////

  rgbPix_s    pix;
  logic       pixValid;
  syncFlags_s sync;
  logic       syncStrobe;

  vidDemux uVidDemux (
    .VCLK         (VCLK),
    .rst_i        (rst_i),
    .nVDSYNC_i    (nVDSYNC_i),
    .vd_i         (vd_i),
    .pix_o        (pix),
    .pixValid_o   (pixValid),
    .sync_o       (sync),
    .syncStrobe_o (syncStrobe)
  );

  colorFormatter uColorFormatter (
    .VCLK         (VCLK),
    .rst_i        (rst_i),
    .pix_i        (pix),
    .pixValid_i   (pixValid),
    .sync_i       (sync),
    .syncStrobe_i (syncStrobe),
    .cfg          (cfg.formatter),
    .vdR_o        (vdR_o),
    .vdG_o        (vdG_o),
    .vdB_o        (vdB_o),
    .pixValid_o   (pixValid_o),
    .nCSYNC_o     (nCSYNC_o),
    .nHSYNC_o     (nHSYNC_o),
    .nVSYNC_o     (nVSYNC_o)
  );

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/n64vid_pkg.sv
common/cfgLink_if.sv
config/settleTimer.sv
config/cfgSequencer.sv
demux/vidDemux.sv
convert/colorFormatter.sv
hw/n64vidTop.sv
bench/n64vidTb.sv
